// ==== Bender.yml ====
package:
  name: dekatron_counter_unit

sources:
  - include_dirs:
      - include
    files:
      - logic/dekatronPkg.sv
      - logic/commandPkg.sv
      - logic/dekatronRing.sv
      - logic/dekatronCounter.sv
      - logic/counterSequencer.sv
      - logic/dekatronCounterUnit.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/dekatronCounterUnitTb.sv

// ==== dekatronCounterUnit.f ====
+incdir+include
logic/dekatronPkg.sv
logic/commandPkg.sv
logic/dekatronRing.sv
logic/dekatronCounter.sv
logic/counterSequencer.sv
logic/dekatronCounterUnit.sv
verification/dekatronCounterUnitTb.sv

// ==== include/dekatron_params.svh ====
`ifndef DEKATRON_PARAMS_SVH
`define DEKATRON_PARAMS_SVH

// Glow positions around one decade ring
`define DEK_POSITIONS 10

// Decade rings chained into one counter
`define DEK_DIGITS 3

// Highest value the counter holds before it wraps to 000
`define DEK_COUNT_MAX 255

`endif

// ==== logic/commandPkg.sv ====
package commandPkg;

	// Operations a requester can issue
	typedef enum logic [1:0] {
		load     = 2'd0,
		stepUp   = 2'd1,
		stepDown = 2'd2,
		read     = 2'd3
	} cmdOpT;

	// Request payload, operand is the step count for step commands
	typedef struct packed {
		cmdOpT op;
		dekatronPkg::bcdValueT operand;
	} counterCmdT;

	// Response payload, held while cmdAck is high
	typedef struct packed {
		dekatronPkg::bcdValueT value;
		logic error;
	} counterRspT;

endpackage

// ==== logic/counterSequencer.sv ====
`timescale 1ns/100ps
`include "dekatron_params.svh"

module counterSequencer (
	input logic step,
	input logic arstN,
	input logic cmdReq,
	output logic cmdAck,
	input commandPkg::counterCmdT cmd,
	output commandPkg::counterRspT rsp,
	input dekatronPkg::bcdValueT dataValue,
	output logic dataEn,
	output logic dataReverse,
	output logic dataLoad,
	output logic budgetEn,
	output logic budgetLoad,
	input logic budgetAtMin
);
	import commandPkg::*;

	typedef enum logic [1:0] {
		stIdle,
		stStepping,
		stDone,
		stRelease
	} stateT;

	stateT state;
	logic errFlag;
	logic digitsValid;
	logic operandValid;
	int operandNum;
	logic accept;
	logic isStep;
	logic stepping;

	// Digits must be clean BCD before the range test means anything
	always_comb begin
		digitsValid = (cmd.operand.hundreds <= 4'd9) &&
			(cmd.operand.tens <= 4'd9) &&
			(cmd.operand.ones <= 4'd9);
		operandNum = int'(cmd.operand.hundreds) * 100 +
			int'(cmd.operand.tens) * 10 +
			int'(cmd.operand.ones);
		operandValid = digitsValid && (operandNum <= `DEK_COUNT_MAX);
	end

	assign accept = (state == stIdle) && cmdReq;
	assign isStep = (cmd.op == stepUp) || (cmd.op == stepDown);

	// Loads land on the edge that accepts the command
	assign dataLoad = accept && (cmd.op == load) && operandValid;
	assign budgetLoad = accept && isStep;

	// One data step per cycle while budget remains
	assign stepping = (state == stStepping) && !budgetAtMin;
	assign dataEn = stepping;
	assign budgetEn = stepping;
	assign dataReverse = (cmd.op == stepDown);

	always_ff @(posedge step or negedge arstN) begin
		if (!arstN) begin
			state <= stIdle;
			cmdAck <= 1'b0;
			errFlag <= 1'b0;
		end else begin
			case (state)
				stIdle: begin
					if (cmdReq) begin
						errFlag <= (cmd.op == load) && !operandValid;
						state <= isStep ? stStepping : stDone;
					end
				end
				stStepping: begin
					// Budget empty, data counter has settled
					if (budgetAtMin) state <= stDone;
				end
				stDone: begin
					cmdAck <= 1'b1;
					state <= stRelease;
				end
				stRelease: begin
					// Hold the response until the requester lets go
					if (!cmdReq) begin
						cmdAck <= 1'b0;
						state <= stIdle;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	// Response snapshot taken as cmdAck rises
	always_ff @(posedge step) begin
		if (state == stDone) begin
			rsp <= '{value: dataValue, error: errFlag};
		end
	end

	// cmdAck only rises into a pending request
	assert property (@(posedge step) disable iff (!arstN)
		$rose(cmdAck) |-> cmdReq && $past(cmdReq));

	// Acknowledge held as long as the request is
	assert property (@(posedge step) disable iff (!arstN)
		cmdAck && cmdReq |=> cmdAck);

endmodule

// ==== logic/dekatronCounter.sv ====
`timescale 1ns/100ps
`include "dekatron_params.svh"

module dekatronCounter (
	input logic step,
	input logic arstN,
	input logic countEn,
	input logic reverse,
	input logic load,
	input dekatronPkg::bcdValueT loadValue,
	output dekatronPkg::bcdValueT value,
	output logic atMin,
	output logic atMax
);
	import dekatronPkg::*;

	localparam int unsigned Digits = `DEK_DIGITS;
	localparam int unsigned Last = `DEK_POSITIONS - 1;
	localparam int unsigned Max = `DEK_COUNT_MAX;

	// Wrap value in BCD, 255 with the default limit
	localparam bcdValueT MaxBcd = '{
		hundreds: bcdDigitT'(Max / 100),
		tens: bcdDigitT'((Max / 10) % 10),
		ones: bcdDigitT'(Max % 10)
	};
	localparam bcdBankT MaxDigits = bcdBankT'(MaxBcd);

	ringBankT positions;
	ringBankT setBank;
	bcdBankT loadDigits;
	bcdBankT valueDigits;
	logic [Digits-1:0] ringEn;
	logic wrapUp;
	logic wrapDown;
	logic setAll;

	// Out of range digits land on position 0
	function automatic ringT digitToRing(bcdDigitT d);
		ringT r;
		r = '0;
		if (d <= bcdDigitT'(Last)) begin
			r[d] = 1'b1;
		end else begin
			r[0] = 1'b1;
		end
		return r;
	endfunction

	function automatic bcdDigitT ringToDigit(ringT r);
		bcdDigitT d;
		d = '0;
		for (int i = 0; i < `DEK_POSITIONS; i++) begin
			if (r[i]) d = bcdDigitT'(i);
		end
		return d;
	endfunction

	function automatic int unsigned bcdToNum(bcdValueT v);
		return v.hundreds * 100 + v.tens * 10 + v.ones;
	endfunction

	assign loadDigits = bcdBankT'(loadValue);

	assign atMax = (value == MaxBcd);
	assign atMin = (value == '0);

	// Stepping past a limit reloads the opposite limit
	assign wrapUp = countEn & ~reverse & atMax;
	assign wrapDown = countEn & reverse & atMin;
	assign setAll = load | wrapUp | wrapDown;

	always_comb begin
		for (int i = 0; i < Digits; i++) begin
			if (load) begin
				setBank[i] = digitToRing(loadDigits[i]);
			end else if (wrapDown) begin
				setBank[i] = digitToRing(MaxDigits[i]);
			end else begin
				setBank[i] = ringT'(1);
			end
		end
	end

	// Carry ripples up while the lower ring sits at its turnover position
	always_comb begin
		ringEn[0] = countEn;
		for (int i = 1; i < Digits; i++) begin
			ringEn[i] = ringEn[i-1] &
				(reverse ? positions[i-1][0] : positions[i-1][Last]);
		end
	end

	for (genvar g = 0; g < Digits; g++) begin : gRing
		dekatronRing ring (
			.step(step),
			.arstN(arstN),
			.en(ringEn[g]),
			.reverse(reverse),
			.set(setAll),
			.setValue(setBank[g]),
			.position(positions[g])
		);
		assign valueDigits[g] = ringToDigit(positions[g]);
	end

	assign value = bcdValueT'(valueDigits);

	// An in-range count stays in range through steps and wraps
	assert property (@(posedge step) disable iff (!arstN)
		(load ? bcdToNum(loadValue) <= Max : bcdToNum(value) <= Max)
		|=> bcdToNum(value) <= Max);

endmodule

// ==== logic/dekatronCounterUnit.sv ====
`timescale 1ns/100ps

module dekatronCounterUnit (
	input logic step,
	input logic arstN,
	input logic cmdReq,
	output logic cmdAck,
	input commandPkg::counterCmdT cmd,
	output commandPkg::counterRspT rsp,
	output dekatronPkg::bcdValueT countValue
);
	logic dataEn;
	logic dataReverse;
	logic dataLoad;
	logic budgetEn;
	logic budgetLoad;
	logic budgetAtMin;

	counterSequencer sequencer (
		.step(step),
		.arstN(arstN),
		.cmdReq(cmdReq),
		.cmdAck(cmdAck),
		.cmd(cmd),
		.rsp(rsp),
		.dataValue(countValue),
		.dataEn(dataEn),
		.dataReverse(dataReverse),
		.dataLoad(dataLoad),
		.budgetEn(budgetEn),
		.budgetLoad(budgetLoad),
		.budgetAtMin(budgetAtMin)
	);

	// Counter the requester sees
	dekatronCounter dataCounter (
		.step(step),
		.arstN(arstN),
		.countEn(dataEn),
		.reverse(dataReverse),
		.load(dataLoad),
		.loadValue(cmd.operand),
		.value(countValue),
		.atMin(),
		.atMax()
	);

	// Step store, only ever counts down to 000
	dekatronCounter budgetCounter (
		.step(step),
		.arstN(arstN),
		.countEn(budgetEn),
		.reverse(1'b1),
		.load(budgetLoad),
		.loadValue(cmd.operand),
		.value(),
		.atMin(budgetAtMin),
		.atMax()
	);

endmodule

// ==== logic/dekatronPkg.sv ====
`include "dekatron_params.svh"

package dekatronPkg;

	// One-hot glow position, bit n lit means digit n
	typedef logic [`DEK_POSITIONS-1:0] ringT;

	// All rings of one counter, index 0 is the ones ring
	typedef ringT [`DEK_DIGITS-1:0] ringBankT;

	// Single 8-4-2-1 digit
	typedef logic [3:0] bcdDigitT;

	// Digits in ring order, same bit layout as bcdValueT
	typedef bcdDigitT [`DEK_DIGITS-1:0] bcdBankT;

	// Three digit BCD value, ones in the low nibble
	typedef struct packed {
		bcdDigitT hundreds;
		bcdDigitT tens;
		bcdDigitT ones;
	} bcdValueT;

endpackage

// ==== logic/dekatronRing.sv ====
`timescale 1ns/100ps
`include "dekatron_params.svh"

module dekatronRing (
	input logic step,
	input logic arstN,
	input logic en,
	input logic reverse,
	input logic set,
	input dekatronPkg::ringT setValue,
	output dekatronPkg::ringT position
);
	import dekatronPkg::*;

	localparam int unsigned Last = `DEK_POSITIONS - 1;

	// Glow position held as a rotating one-hot vector
	always_ff @(posedge step or negedge arstN) begin
		if (!arstN) begin
			position <= ringT'(1);
		end else if (set) begin
			position <= setValue;
		end else if (en) begin
			if (reverse) begin
				// Glow moves toward lower digits, 0 wraps to 9
				position <= {position[0], position[Last:1]};
			end else begin
				position <= {position[Last-1:0], position[Last]};
			end
		end
	end

	// Exactly one glow on the ring at any step
	assert property (@(posedge step) disable iff (!arstN)
		$onehot(position));

endmodule

// ==== verification/dekatronCounterUnitTb.sv ====
`timescale 1ns/100ps
`include "dekatron_params.svh"

module dekatronCounterUnitTb;
	import dekatronPkg::*;
	import commandPkg::*;

	localparam int ClkPeriod = 20;
	localparam int ResetCycles = 8;
	localparam int Modulus = `DEK_COUNT_MAX + 1;
	localparam int DirectedCount = 8;
	localparam int RandomCount = 40;
	localparam int TotalCount = DirectedCount + RandomCount;
	localparam int CyclesPerCommand = 260;

	logic step;
	logic arstN;
	logic cmdReq;
	logic cmdAck;
	counterCmdT cmd;
	counterRspT rsp;
	bcdValueT countValue;

	integer seed;
	int modelValue;
	counterRspT expRsp;
	int expLatency;
	int reqEdges;
	int valueErrors = 0;
	int handshakeErrors = 0;
	int latencyErrors = 0;

	dekatronCounterUnit i_dut (
		.step(step),
		.arstN(arstN),
		.cmdReq(cmdReq),
		.cmdAck(cmdAck),
		.cmd(cmd),
		.rsp(rsp),
		.countValue(countValue)
	);

	initial begin
		step = 1'b0;
		forever #(ClkPeriod / 2) step = ~step;
	end

	// Decimal to three BCD digits, good for 0 to 999
	function automatic bcdValueT toBcd(int n);
		bcdValueT v;
		v.hundreds = bcdDigitT'(n / 100);
		v.tens = bcdDigitT'((n / 10) % 10);
		v.ones = bcdDigitT'(n % 10);
		return v;
	endfunction

	function automatic int bcdToInt(bcdValueT v);
		return v.hundreds * 100 + v.tens * 10 + v.ones;
	endfunction

	function automatic logic loadIsValid(bcdValueT v);
		return (v.hundreds <= 9) && (v.tens <= 9) && (v.ones <= 9) &&
			(bcdToInt(v) < Modulus);
	endfunction

	// Edges since cmdReq was first sampled high, -1 while no request waits
	always @(posedge step or negedge arstN) begin
		if (!arstN) begin
			reqEdges <= -1;
		end else if (cmdReq && !cmdAck) begin
			reqEdges <= reqEdges + 1;
		end else begin
			reqEdges <= -1;
		end
	end

	// Model update first, then one full four-phase exchange
	task automatic issueCommand(input cmdOpT op, input bcdValueT operand, input int hold);
		int n;
		logic err;
		n = bcdToInt(operand);
		err = 1'b0;
		case (op)
			load: begin
				if (loadIsValid(operand)) begin
					modelValue = n;
				end else begin
					err = 1'b1;
				end
			end
			stepUp: modelValue = (modelValue + n) % Modulus;
			stepDown: modelValue = (modelValue + Modulus - n) % Modulus;
			default: ;
		endcase
		@(posedge step);
		cmd <= '{op: op, operand: operand};
		cmdReq <= 1'b1;
		expRsp <= '{value: toBcd(modelValue), error: err};
		expLatency <= (op == stepUp || op == stepDown) ? n + 2 : 1;
		do @(posedge step); while (!cmdAck);
		repeat (hold) @(posedge step);
		cmdReq <= 1'b0;
		do @(posedge step); while (cmdAck);
	endtask

	task automatic runDirected();
		bcdValueT badDigit;
		badDigit = '{hundreds: 4'd0, tens: 4'd12, ones: 4'd7};
		// Runs through 255 and wraps to 004
		issueCommand(load, toBcd(250), 0);
		issueCommand(stepUp, toBcd(10), 1);
		// Borrow through 000 back up to 254
		issueCommand(load, toBcd(3), 0);
		issueCommand(stepDown, toBcd(5), 2);
		issueCommand(stepUp, toBcd(0), 0);
		issueCommand(load, badDigit, 0);
		issueCommand(load, toBcd(256), 3);
		issueCommand(read, toBcd(0), 0);
	endtask

	task automatic runRandom();
		cmdOpT op;
		bcdValueT operand;
		int pick;
		int hold;
		for (int i = 0; i < RandomCount; i++) begin
			op = cmdOpT'({$random(seed)} % 4);
			pick = {$random(seed)} % 8;
			if (op == stepUp || op == stepDown) begin
				operand = toBcd({$random(seed)} % 200);
			end else if (op == load && pick == 0) begin
				// One digit pushed past 9
				operand = toBcd({$random(seed)} % Modulus);
				operand.tens = bcdDigitT'(10 + {$random(seed)} % 6);
			end else if (op == load && pick == 1) begin
				operand = toBcd(Modulus + {$random(seed)} % 44);
			end else begin
				operand = toBcd({$random(seed)} % Modulus);
			end
			hold = ({$random(seed)} % 3 == 0) ? {$random(seed)} % 4 : 0;
			issueCommand(op, operand, hold);
		end
	endtask

	// Out of reset
	assert property (@(posedge step) $rose(arstN) |-> countValue == '0)
	else begin
		valueErrors++;
		$display("mismatch at %0t: countValue expected 000 actual %h", $time,
			$sampled(countValue));
	end
	assert property (@(posedge step) $rose(arstN) |-> !cmdAck)
	else begin
		handshakeErrors++;
		$display("cmdAck was high at %0t right after reset", $time);
	end

	// Response and live value at the acknowledge
	assert property (@(posedge step) disable iff (!arstN) $rose(cmdAck) |-> rsp == expRsp)
	else begin
		valueErrors++;
		$display("mismatch at %0t: rsp expected %h/%b actual %h/%b", $time, expRsp.value,
			expRsp.error, $sampled(rsp.value), $sampled(rsp.error));
	end
	assert property (@(posedge step) disable iff (!arstN)
		$rose(cmdAck) |-> countValue == expRsp.value)
	else begin
		valueErrors++;
		$display("mismatch at %0t: countValue expected %h actual %h", $time,
			expRsp.value, $sampled(countValue));
	end
	assert property (@(posedge step) disable iff (!arstN)
		$rose(cmdAck) |-> reqEdges == expLatency)
	else begin
		latencyErrors++;
		$display("mismatch at %0t: cmdAck latency expected %0d actual %0d", $time,
			expLatency, $sampled(reqEdges));
	end

	// Four-phase ordering
	assert property (@(posedge step) disable iff (!arstN) $rose(cmdAck) |-> cmdReq)
	else begin
		handshakeErrors++;
		$display("cmdAck rose at %0t while cmdReq was low", $time);
	end
	assert property (@(posedge step) disable iff (!arstN) cmdAck && cmdReq |=> cmdAck)
	else begin
		handshakeErrors++;
		$display("cmdAck fell at %0t while cmdReq was still high", $time);
	end
	assert property (@(posedge step) disable iff (!arstN) cmdAck && !cmdReq |=> !cmdAck)
	else begin
		handshakeErrors++;
		$display("cmdAck stayed high at %0t after cmdReq fell", $time);
	end
	// No new command is taken while the old one is still acknowledged
	assert property (@(posedge step) disable iff (!arstN) cmdAck |=> $stable(countValue))
	else begin
		handshakeErrors++;
		$display("countValue changed at %0t while cmdAck was high", $time);
	end
	assert property (@(posedge step) disable iff (!arstN)
		cmdAck && $past(cmdAck) |-> $stable(rsp))
	else begin
		handshakeErrors++;
		$display("rsp changed at %0t while cmdAck was high", $time);
	end

	// Longest step command plus handshake stays well under 260 cycles
	initial begin
		#((TotalCount * CyclesPerCommand + ResetCycles) * ClkPeriod);
		$display("Timeout at %0t: the cmdReq/cmdAck handshake hung", $time);
		$display("Test failed");
		$finish;
	end

	initial begin
		seed = 48707;
		modelValue = 0;
		expRsp = '0;
		expLatency = 0;
		cmdReq = 1'b0;
		cmd = '0;
		arstN = 1'b0;
		repeat (ResetCycles) @(posedge step);
		arstN <= 1'b1;
		repeat (2) @(posedge step);
		runDirected();
		runRandom();
		repeat (4) @(posedge step);
		$display("Errors: value %0d, handshake %0d, latency %0d",
			valueErrors, handshakeErrors, latencyErrors);
		if (valueErrors + handshakeErrors + latencyErrors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
